// ==== filelist.f ====
+incdir+logic
logic/dc_pkg.sv
logic/dc_info_update.sv
logic/dc_state_array.sv
logic/dc_req_intake.sv
logic/dc_info_queue.sv
logic/dc_info_top.sv
bench/tb_clkgen.sv
bench/dc_info_tb.sv

// ==== Makefile ====
# Verilator build and run of the line-info tracker testbench
VERILATOR ?= verilator
TOP       ?= dc_info_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "No pass line found in $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/dc_info_tb.sv ====
// Inputs change on falling edges, outputs are checked on rising edges against a model of the rules
`include "dc_macros.svh"

module dc_info_tb import dc_pkg::*; ;

  localparam int DEPTH       = `DC_Q_DEPTH;
  localparam int SETS        = 1 << `DC_IDX_W;
  localparam int WAIT_LIMIT  = 300;
  localparam int RAND_CYCLES = 400;

  logic     clk;
  logic     arst_n;
  logic     req_vld;
  dc_req_t  req;
  logic     req_credit;
  logic     wr_vld;
  dc_wr_t   wr;
  logic     resp_vld;
  dc_resp_t resp;
  logic     resp_credit;

  // Model of the arrays and of the queued entries
  logic [1:0][`DC_TAG_W-1:0] m_tag   [SETS];
  logic [1:0][2:0]           m_state [SETS];
  dc_resp_t                  model_q [$];
  dc_req_t                   pending;
  logic                      pending_vld;
  logic                      pop_prev;

  int   up_credits    = DEPTH;
  int   credit_pulses = 0;
  int   resp_count    = 0;
  int   credits_back  = 0;
  int   checks        = 0;
  int   errors        = 0;
  int   check_mark    = 0;
  int   err_mark      = 0;
  int   test_num      = 0;
  logic hold_credit   = 1'b0;
  logic timed_out     = 1'b0;

  tb_clkgen u_clkgen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  dc_info_top dut (
    .forever_cpuclk (clk),
    .arst_n         (arst_n),
    .req_vld        (req_vld),
    .req            (req),
    .req_credit     (req_credit),
    .wr_vld         (wr_vld),
    .wr             (wr),
    .resp_vld       (resp_vld),
    .resp           (resp),
    .resp_credit    (resp_credit)
  );

  function automatic logic [`DC_ADDR_W-1:0] make_addr(input int tag, input int idx, input int off);
    return {tag[`DC_TAG_W-1:0], idx[`DC_IDX_W-1:0], off[`DC_OFF_W-1:0]};
  endfunction

  // Refill one way with its tag and all three {dirty, share, valid} bits
  function automatic dc_wr_t refill_wr(input logic [`DC_ADDR_W-1:0] addr, input int way,
                                       input logic [2:0] bits);
    dc_wr_t w;
    w = '0;
    w.idx = addr[`DC_OFF_W +: `DC_IDX_W];
    w.tag_gwen = 1'b1;
    w.tag_wen[way] = 1'b1;
    w.tag_din[way] = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    w.dirty_gwen = 1'b1;
    w.dirty_wen[3*way +: 3] = 3'b111;
    w.dirty_din[3*way +: 3] = bits;
    return w;
  endfunction

  function automatic dc_wr_t state_wr(input logic [`DC_ADDR_W-1:0] addr, input int way,
                                      input logic [2:0] en, input logic [2:0] din);
    dc_wr_t w;
    w = '0;
    w.idx = addr[`DC_OFF_W +: `DC_IDX_W];
    w.dirty_gwen = 1'b1;
    w.dirty_wen[3*way +: 3] = en;
    w.dirty_din[3*way +: 3] = din;
    return w;
  endfunction

  // Reference rules for one entry and one write
  function automatic dc_line_info_t next_info(input dc_line_info_t cur, input logic wv,
                                              input dc_wr_t w, input logic [`DC_ADDR_W-1:0] addr,
                                              input logic sw);
    dc_line_info_t        res;
    logic [2:0]           en;
    logic [2:0]           din;
    logic [`DC_TAG_W-1:0] tag;
    int                   fill_way;
    res = cur;
    tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    if (!wv || !w.dirty_gwen || addr[`DC_OFF_W +: `DC_IDX_W] != w.idx) begin
      return res;
    end
    // Hit and set/way updates take the enabled fields of the entry's own way
    if (sw || cur.valid) begin
      en  = w.dirty_wen[3*cur.way +: 3];
      din = w.dirty_din[3*cur.way +: 3];
      if (en[2]) res.dirty = din[2];
      if (en[1]) res.share = din[1];
      if (en[0]) res.valid = din[0];
      return res;
    end
    fill_way = -1;
    for (int k = 0; k < 2; k++) begin
      if (w.tag_gwen && w.tag_wen[k] && w.tag_din[k] == tag
          && w.dirty_wen[3*k] && w.dirty_din[3*k]) begin
        fill_way = k;
      end
    end
    if (fill_way >= 0) begin
      din = w.dirty_din[3*fill_way +: 3];
      res.dirty = din[2];
      res.share = din[1];
      res.valid = din[0];
      res.way   = fill_way[0];
    end
    return res;
  endfunction

  function automatic dc_line_info_t lookup_origin(input dc_req_t r);
    dc_line_info_t        res;
    logic [`DC_IDX_W-1:0] idx;
    logic [`DC_TAG_W-1:0] tag;
    int                   way;
    idx = r.addr[`DC_OFF_W +: `DC_IDX_W];
    tag = r.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    way = -1;
    if (r.sw_inst) begin
      way = int'(r.addr[0]);
    end else if (m_state[idx][0][0] && m_tag[idx][0] == tag) begin
      way = 0;
    end else if (m_state[idx][1][0] && m_tag[idx][1] == tag) begin
      way = 1;
    end
    res = '0;
    if (way >= 0) begin
      res.dirty = m_state[idx][way][2];
      res.share = m_state[idx][way][1];
      res.valid = m_state[idx][way][0];
      res.way   = way[0];
    end
    return res;
  endfunction

  task automatic apply_write();
    if (wr_vld && wr.tag_gwen) begin
      for (int k = 0; k < 2; k++) begin
        if (wr.tag_wen[k]) m_tag[wr.idx][k] = wr.tag_din[k];
      end
    end
    if (wr_vld && wr.dirty_gwen) begin
      for (int b = 0; b < 6; b++) begin
        if (wr.dirty_wen[b]) m_state[wr.idx][b/3][b%3] = wr.dirty_din[b];
      end
    end
  endtask

  // Check the popped entry and advance the model at each rising edge
  task automatic check_edge();
    dc_resp_t      exp;
    dc_line_info_t origin;
    if (req_credit) begin
      up_credits++;
      credit_pulses++;
    end
    checks++;
    assert (req_credit === pop_prev) else begin
      $display("Error: time %0t, req_credit got %0b, expected %0b", $time, req_credit, pop_prev);
      errors++;
    end
    pop_prev = resp_vld;
    if (resp_vld) begin
      resp_count++;
      if (model_q.size() == 0) begin
        $display("Error: time %0t, a response came with no request outstanding", $time);
        errors++;
      end else begin
        exp = model_q.pop_front();
        exp.info = next_info(exp.info, wr_vld, wr, exp.addr, exp.sw_inst);
        checks++;
        assert (resp === exp) else begin
          $display("Error: time %0t, resp got addr %h sw %b info %b, expected addr %h sw %b info %b",
                   $time, resp.addr, resp.sw_inst, resp.info, exp.addr, exp.sw_inst, exp.info);
          errors++;
        end
      end
    end
    foreach (model_q[i]) begin
      model_q[i].info = next_info(model_q[i].info, wr_vld, wr, model_q[i].addr, model_q[i].sw_inst);
    end
    // Lookup cycle uses the arrays before this edge's write
    if (pending_vld) begin
      origin = lookup_origin(pending);
      exp.addr = pending.addr;
      exp.sw_inst = pending.sw_inst;
      exp.info = next_info(origin, wr_vld, wr, pending.addr, pending.sw_inst);
      model_q.push_back(exp);
    end
    apply_write();
    pending_vld = req_vld;
    pending = req;
  endtask

  initial begin
    for (int s = 0; s < SETS; s++) begin
      m_state[s] = '0;
    end
    pending_vld = 1'b0;
    pending = '0;
    pop_prev = 1'b0;
    forever begin
      @(posedge clk);
      if (arst_n) check_edge();
    end
  end

  // Downstream credits come back at random unless held
  initial begin
    resp_credit = 1'b0;
    forever begin
      @(negedge clk);
      if (!hold_credit && arst_n && resp_count > credits_back && ($urandom % 3) != 0) begin
        resp_credit = 1'b1;
        credits_back++;
      end else begin
        resp_credit = 1'b0;
      end
    end
  end

  // No new stimulus once a wait has given up
  task automatic drive(input logic rv, input dc_req_t r, input logic wv, input dc_wr_t w);
    if (!timed_out) begin
      @(negedge clk);
      req_vld = rv;
      req = r;
      wr_vld = wv;
      wr = w;
      if (rv) up_credits--;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, '0, 1'b0, '0);
  endtask

  task automatic send_write(input dc_wr_t w);
    drive(1'b0, '0, 1'b1, w);
  endtask

  task automatic send_req(input logic [`DC_ADDR_W-1:0] addr, input logic sw);
    dc_req_t r;
    int      n;
    r.addr = addr;
    r.sw_inst = sw;
    n = 0;
    while (up_credits == 0 && !timed_out && n < WAIT_LIMIT) begin
      idle(1);
      n++;
    end
    if (up_credits == 0 && !timed_out) begin
      $display("Timeout: no upstream credit came back within %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
    end else begin
      drive(1'b1, r, 1'b0, '0);
    end
  endtask

  task automatic wait_resp(input int target);
    int n;
    n = 0;
    while (resp_count < target && !timed_out && n < WAIT_LIMIT) begin
      idle(1);
      n++;
    end
    if (resp_count < target && !timed_out) begin
      $display("Timeout: only %0d of %0d responses arrived", resp_count, target);
      timed_out = 1'b1;
    end
  endtask

  // True until every entry has left and every credit is home
  function automatic logic queue_busy();
    return model_q.size() != 0 || pending_vld || resp_count != credits_back
           || up_credits != DEPTH;
  endfunction

  task automatic wait_drain();
    int n;
    n = 0;
    while (queue_busy() && !timed_out && n < WAIT_LIMIT) begin
      idle(1);
      n++;
    end
    if (queue_busy() && !timed_out) begin
      $display("Timeout: the queue did not drain, %0d entries left", model_q.size());
      timed_out = 1'b1;
    end
  endtask

  // Use up all downstream credits so that later entries stay queued
  task automatic block_resp();
    int target;
    hold_credit = 1'b1;
    target = resp_count + DEPTH;
    for (int i = 0; i < DEPTH; i++) begin
      send_req(make_addr(1, 100, i), 1'b0);
    end
    wait_resp(target);
  endtask

  task automatic release_resp();
    hold_credit = 1'b0;
    wait_drain();
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
             checks - check_mark, errors - err_mark);
    check_mark = checks;
    err_mark = errors;
  endtask

  task automatic test_refill_lookup();
    send_write(refill_wr(make_addr(5, 3, 0), 1, 3'b001));
    idle(1);
    send_req(make_addr(5, 3, 12), 1'b0);
    send_req(make_addr(6, 3, 0), 1'b0);
    // Refill lands in the lookup cycle
    send_req(make_addr(7, 4, 0), 1'b0);
    send_write(refill_wr(make_addr(7, 4, 0), 0, 3'b101));
    wait_drain();
  endtask

  task automatic test_hit_update();
    logic [`DC_ADDR_W-1:0] a;
    a = make_addr(9, 10, 0);
    send_write(refill_wr(a, 0, 3'b001));
    idle(1);
    block_resp();
    send_req(a, 1'b0);
    send_req(a, 1'b0);
    idle(2);
    send_write(state_wr(a, 0, 3'b100, 3'b100));
    send_write(state_wr(a, 0, 3'b010, 3'b010));
    send_write(state_wr(a, 0, 3'b001, 3'b001));
    send_write(state_wr(a, 1, 3'b111, 3'b110));
    send_write(state_wr(make_addr(9, 11, 0), 0, 3'b111, 3'b000));
    release_resp();
  endtask

  task automatic test_miss_refill();
    logic [`DC_ADDR_W-1:0] a;
    a = make_addr(3, 20, 8);
    block_resp();
    send_req(a, 1'b0);
    idle(2);
    send_write(refill_wr(make_addr(4, 20, 0), 0, 3'b001));
    send_write(refill_wr(make_addr(3, 21, 0), 1, 3'b001));
    send_write(refill_wr(a, 1, 3'b011));
    send_req(a, 1'b0);
    send_write(state_wr(a, 1, 3'b100, 3'b100));
    release_resp();
  endtask

  task automatic test_set_way();
    block_resp();
    send_req(make_addr(12, 30, 1), 1'b1);
    send_req(make_addr(12, 30, 0), 1'b1);
    idle(2);
    send_write(state_wr(make_addr(12, 30, 0), 1, 3'b110, 3'b110));
    send_write(refill_wr(make_addr(12, 30, 0), 0, 3'b001));
    send_write(state_wr(make_addr(0, 31, 0), 1, 3'b111, 3'b100));
    release_resp();
  endtask

  task automatic test_backpressure();
    int base;
    int pulses;
    base = resp_count;
    pulses = credit_pulses;
    hold_credit = 1'b1;
    for (int i = 0; i < 2 * DEPTH; i++) begin
      send_req(make_addr(i, 60 + i, 4 * i), 1'b0);
    end
    // Nothing more may leave while credits are held
    idle(20);
    checks++;
    assert (resp_count - base == DEPTH) else begin
      $display("Error: time %0t, resp_vld count got %0d, expected %0d", $time,
               resp_count - base, DEPTH);
      errors++;
    end
    // One upstream credit per response that left
    checks++;
    assert (credit_pulses - pulses == DEPTH) else begin
      $display("Error: time %0t, req_credit count got %0d, expected %0d", $time,
               credit_pulses - pulses, DEPTH);
      errors++;
    end
    release_resp();
  endtask

  task automatic test_random();
    dc_req_t               r;
    dc_wr_t                w;
    logic                  rv;
    logic                  wv;
    logic [`DC_ADDR_W-1:0] a;
    logic [2:0]            en;
    logic [2:0]            din;
    int                    way;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      r.addr = make_addr($urandom % 4, $urandom % 4, $urandom % 64);
      r.sw_inst = ($urandom % 8) == 0;
      rv = up_credits > 0 && ($urandom % 2) == 1;
      wv = ($urandom % 2) == 1;
      way = $urandom % 2;
      a = make_addr($urandom % 4, $urandom % 4, 0);
      din = $urandom;
      en = $urandom;
      if (($urandom % 3) == 0) begin
        // Same tag twice in one set would make lookup ambiguous
        if (m_state[a[`DC_OFF_W +: `DC_IDX_W]][1-way][0]
            && m_tag[a[`DC_OFF_W +: `DC_IDX_W]][1-way] == a[`DC_ADDR_W-1 -: `DC_TAG_W]) begin
          way = 1 - way;
        end
        din[0] = 1'b1;
        w = refill_wr(a, way, din);
      end else begin
        // Valid is only ever cleared here, so a valid way always has a written tag
        din[0] = 1'b0;
        w = state_wr(a, way, en, din);
      end
      drive(rv, r, wv, w);
    end
    wait_drain();
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!arst_n && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!arst_n) begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end
  endtask

  initial begin
    void'($urandom(32'h897a));
    req_vld = 1'b0;
    req = '0;
    wr_vld = 1'b0;
    wr = '0;
    wait_reset();
    test_refill_lookup();
    report_test("refill then lookup");
    test_hit_update();
    report_test("hit update");
    test_miss_refill();
    report_test("miss refill while waiting");
    test_set_way();
    report_test("set/way entries");
    test_backpressure();
    report_test("back-pressure and credits");
    test_random();
    report_test("random mix");
    $display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== bench/tb_clkgen.sv ====
// Clock of period 10 starting low; reset held low for 4 rising edges, released on a falling edge
module tb_clkgen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// ==== logic/dc_info_top.sv ====
// Cache write port is external; upstream must start with DC_Q_DEPTH credits
`include "dc_macros.svh"

module dc_info_top import dc_pkg::*; (
  input  logic     forever_cpuclk,
  input  logic     arst_n,
  input  logic     req_vld,
  input  dc_req_t  req,
  output logic     req_credit,
  input  logic     wr_vld,
  input  dc_wr_t   wr,
  output logic     resp_vld,
  output dc_resp_t resp,
  input  logic     resp_credit
);

  logic [`DC_IDX_W-1:0]      rd_idx;
  logic [1:0][`DC_TAG_W-1:0] rd_tag;
  logic [1:0][2:0]           rd_info;
  logic                      push;
  dc_req_t                   push_req;
  dc_line_info_t             push_info;

  dc_req_intake u_intake (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .req_vld        (req_vld),
    .req            (req),
    .wr_vld         (wr_vld),
    .wr             (wr),
    .rd_idx         (rd_idx),
    .rd_tag         (rd_tag),
    .rd_info        (rd_info),
    .push           (push),
    .push_req       (push_req),
    .push_info      (push_info)
  );

  dc_state_array u_array (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .wr_vld         (wr_vld),
    .wr             (wr),
    .rd_idx         (rd_idx),
    .rd_tag         (rd_tag),
    .rd_info        (rd_info)
  );

  dc_info_queue u_queue (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .push           (push),
    .push_req       (push_req),
    .push_info      (push_info),
    .wr_vld         (wr_vld),
    .wr             (wr),
    .resp_credit    (resp_credit),
    .resp_vld       (resp_vld),
    .resp           (resp),
    .req_credit     (req_credit)
  );

endmodule

// ==== logic/dc_info_queue.sv ====
// In-order queue; response info includes a write in the pop cycle; depth must be a power of two
`include "dc_macros.svh"

module dc_info_queue import dc_pkg::*; (
  input  logic          forever_cpuclk,
  input  logic          arst_n,
  input  logic          push,
  input  dc_req_t       push_req,
  input  dc_line_info_t push_info,
  input  logic          wr_vld,
  input  dc_wr_t        wr,
  input  logic          resp_credit,
  output logic          resp_vld,
  output dc_resp_t      resp,
  output logic          req_credit
);

  localparam int DEPTH = `DC_Q_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DEPTH-1:0] ent_vld;
  dc_req_t          ent_req  [DEPTH];
  dc_line_info_t    ent_info [DEPTH];
  dc_line_info_t    upd_info [DEPTH];
  logic [DEPTH-1:0] upd_vld;
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] credit_q;
  logic             full;
  logic             pop;

  // Every entry watches the same write port
  for (genvar i = 0; i < DEPTH; i++) begin : g_ent
    dc_info_update u_update (
      .wr_vld     (wr_vld),
      .wr         (wr),
      .addr       (ent_req[i].addr),
      .sw_inst    (ent_req[i].sw_inst),
      .origin     (ent_info[i]),
      .idx_hit    (),
      .update_vld (upd_vld[i]),
      .updated    (upd_info[i])
    );
  end

  assign full     = ent_vld[tail];
  assign resp_vld = ent_vld[head] && (credit_q != '0);
  assign pop      = resp_vld;

  assign resp.addr    = ent_req[head].addr;
  assign resp.sw_inst = ent_req[head].sw_inst;
  assign resp.info    = upd_info[head];

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      ent_vld    <= '0;
      head       <= '0;
      tail       <= '0;
      credit_q   <= CNT_W'(DEPTH);
      req_credit <= 1'b0;
    end else begin
      if (pop) begin
        ent_vld[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      if (push) begin
        ent_vld[tail] <= 1'b1;
        tail          <= tail + 1'b1;
      end
      credit_q   <= credit_q + CNT_W'(resp_credit) - CNT_W'(pop);
      // Upstream credit goes back one cycle after the pop
      req_credit <= pop;
    end
  end

  // Payload, written on push and on each matching write
  always_ff @(posedge forever_cpuclk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (push && (tail == PTR_W'(i))) begin
        ent_req[i]  <= push_req;
        ent_info[i] <= push_info;
      end else if (ent_vld[i] && upd_vld[i]) begin
        ent_info[i] <= upd_info[i];
      end
    end
  end

  // Upstream credits should make overflow impossible
  a_no_push_full: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    push |-> !full);

  a_credit_max: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    credit_q <= CNT_W'(DEPTH));

endmodule

// ==== logic/dc_req_intake.sv ====
// One request per cycle; the sender must respect credits, there is no stall on this side
`include "dc_macros.svh"

module dc_req_intake import dc_pkg::*; (
  input  logic                       forever_cpuclk,
  input  logic                       arst_n,
  input  logic                       req_vld,
  input  dc_req_t                    req,
  input  logic                       wr_vld,
  input  dc_wr_t                     wr,
  output logic [`DC_IDX_W-1:0]       rd_idx,
  input  logic [1:0][`DC_TAG_W-1:0]  rd_tag,
  input  logic [1:0][2:0]            rd_info,
  output logic                       push,
  output dc_req_t                    push_req,
  output dc_line_info_t              push_info
);

  dc_req_t              req_q;
  logic                 req_vld_q;
  logic [`DC_TAG_W-1:0] req_tag;
  logic                 hit0;
  logic                 hit1;
  logic                 sw_way;
  logic [2:0]           bits;
  dc_line_info_t        origin;

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      req_vld_q <= 1'b0;
    end else begin
      req_vld_q <= req_vld;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (req_vld) begin
      req_q <= req;
    end
  end

  assign rd_idx  = req_q.addr[`DC_OFF_W +: `DC_IDX_W];
  assign req_tag = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

  // A tag match only counts on a valid way
  assign hit0   = rd_info[0][0] && (rd_tag[0] == req_tag);
  assign hit1   = rd_info[1][0] && (rd_tag[1] == req_tag);
  assign sw_way = req_q.addr[0];

  always_comb begin
    if (req_q.sw_inst) begin
      bits       = rd_info[sw_way];
      origin.way = sw_way;
    end else if (hit0) begin
      bits       = rd_info[0];
      origin.way = 1'b0;
    end else if (hit1) begin
      bits       = rd_info[1];
      origin.way = 1'b1;
    end else begin
      bits       = 3'b000;
      origin.way = 1'b0;
    end
    origin.dirty = bits[2];
    origin.share = bits[1];
    origin.valid = bits[0];
  end

  // Fold in a write landing in the lookup cycle
  dc_info_update u_update (
    .wr_vld     (wr_vld),
    .wr         (wr),
    .addr       (req_q.addr),
    .sw_inst    (req_q.sw_inst),
    .origin     (origin),
    .idx_hit    (),
    .update_vld (),
    .updated    (push_info)
  );

  assign push     = req_vld_q;
  assign push_req = req_q;

endmodule

// ==== logic/dc_state_array.sv ====
// Flop-based arrays with combinational read; only state bits are reset, tags come up unknown
`include "dc_macros.svh"

module dc_state_array import dc_pkg::*; (
  input  logic                       forever_cpuclk,
  input  logic                       arst_n,
  input  logic                       wr_vld,
  input  dc_wr_t                     wr,
  input  logic [`DC_IDX_W-1:0]       rd_idx,
  output logic [1:0][`DC_TAG_W-1:0]  rd_tag,
  output logic [1:0][2:0]            rd_info
);

  localparam int SETS = 1 << `DC_IDX_W;

  logic [1:0][`DC_TAG_W-1:0] tag_q   [SETS];
  logic [1:0][2:0]           state_q [SETS];

  // Tag write, masked per way
  always_ff @(posedge forever_cpuclk) begin
    if (wr_vld && wr.tag_gwen) begin
      for (int w = 0; w < 2; w++) begin
        if (wr.tag_wen[w]) begin
          tag_q[wr.idx][w] <= wr.tag_din[w];
        end
      end
    end
  end

  // State write, masked per field
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < SETS; s++) begin
        state_q[s] <= '0;
      end
    end else if (wr_vld && wr.dirty_gwen) begin
      for (int w = 0; w < 2; w++) begin
        for (int b = 0; b < 3; b++) begin
          if (wr.dirty_wen[3*w+b]) begin
            state_q[wr.idx][w][b] <= wr.dirty_din[3*w+b];
          end
        end
      end
    end
  end

  assign rd_tag  = tag_q[rd_idx];
  assign rd_info = state_q[rd_idx];

  // Refill detection in the update blocks relies on this pairing
  a_tag_with_valid: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    (wr_vld && wr.tag_gwen) |->
      (!wr.tag_wen[0] || (wr.dirty_gwen && wr.dirty_wen[0])) &&
      (!wr.tag_wen[1] || (wr.dirty_gwen && wr.dirty_wen[3])));

endmodule

// ==== logic/dc_info_update.sv ====
// Purely combinational; a refill is only seen when the same write also sets the valid bit
`include "dc_macros.svh"

module dc_info_update import dc_pkg::*; (
  input  logic                  wr_vld,
  input  dc_wr_t                wr,
  input  logic [`DC_ADDR_W-1:0] addr,
  input  logic                  sw_inst,
  input  dc_line_info_t         origin,
  output logic                  idx_hit,
  output logic                  update_vld,
  output dc_line_info_t         updated
);

  logic [`DC_TAG_W-1:0] tag;
  logic [2:0]           hit_din;
  logic [2:0]           hit_wen;
  logic                 hit_up;
  logic                 miss_pre;
  logic                 miss_way0_sel;
  logic                 miss_way1_sel;
  logic                 miss_up;
  logic [2:0]           miss_din;
  logic                 sw_up;
  logic                 hit_sel;
  dc_line_info_t        new_info;

  assign tag     = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign idx_hit = addr[`DC_OFF_W +: `DC_IDX_W] == wr.idx;

  // Hit update works on the way the entry already holds
  assign hit_din = origin.way ? wr.dirty_din[5:3] : wr.dirty_din[2:0];
  assign hit_wen = origin.way ? wr.dirty_wen[5:3] : wr.dirty_wen[2:0];
  assign hit_up  = wr_vld && wr.dirty_gwen && origin.valid && idx_hit;

  // Refill of a missing line, never for set/way entries
  assign miss_pre = wr_vld && wr.tag_gwen && wr.dirty_gwen && !sw_inst
                    && !origin.valid && idx_hit;

  assign miss_way0_sel = wr.tag_wen[0] && wr.dirty_wen[0] && wr.dirty_din[0]
                         && (tag == wr.tag_din[0]);
  assign miss_way1_sel = wr.tag_wen[1] && wr.dirty_wen[3] && wr.dirty_din[3]
                         && (tag == wr.tag_din[1]);

  assign miss_up  = miss_pre && (miss_way0_sel || miss_way1_sel);
  assign miss_din = miss_way1_sel ? wr.dirty_din[5:3] : wr.dirty_din[2:0];

  // Set/way entries take any state write to their index
  assign sw_up = wr_vld && wr.dirty_gwen && sw_inst && idx_hit;

  assign update_vld = hit_up || miss_up || sw_up;
  assign hit_sel    = origin.valid || sw_inst;

  always_comb begin
    if (hit_sel) begin
      new_info.dirty = hit_wen[2] ? hit_din[2] : origin.dirty;
      new_info.share = hit_wen[1] ? hit_din[1] : origin.share;
      new_info.valid = hit_wen[0] ? hit_din[0] : origin.valid;
      new_info.way   = origin.way;
    end else begin
      new_info.dirty = miss_din[2];
      new_info.share = miss_din[1];
      new_info.valid = miss_din[0];
      new_info.way   = miss_way1_sel;
    end
  end

  // No matching write keeps the origin
  assign updated = update_vld ? new_info : origin;

endmodule

// ==== logic/dc_pkg.sv ====
// Types shared by the line-info tracker; field widths come from dc_macros.svh
`include "dc_macros.svh"

package dc_pkg;

  // One line's state as seen by a queued request
  typedef struct packed {
    logic valid;
    logic share;
    logic dirty;
    logic way;
  } dc_line_info_t;

  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic                  sw_inst;
  } dc_req_t;

  // Array write port, state fields are {dirty, share, valid} per way, way 1 on top
  typedef struct packed {
    logic [`DC_IDX_W-1:0]       idx;
    logic                       tag_gwen;
    logic [1:0]                 tag_wen;
    logic [1:0][`DC_TAG_W-1:0]  tag_din;
    logic                       dirty_gwen;
    logic [5:0]                 dirty_wen;
    logic [5:0]                 dirty_din;
  } dc_wr_t;

  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic                  sw_inst;
    dc_line_info_t         info;
  } dc_resp_t;

endpackage

// ==== logic/dc_macros.svh ====
// Widths for a 32-bit address, 64-byte lines, 128 sets; DC_Q_DEPTH must be a power of two
`ifndef DC_MACROS_SVH
`define DC_MACROS_SVH

// Address split
`define DC_ADDR_W 32
`define DC_OFF_W 6
`define DC_IDX_W 7
`define DC_TAG_W (`DC_ADDR_W - `DC_IDX_W - `DC_OFF_W)

// Queue entries, also the number of upstream credits
`define DC_Q_DEPTH 4

`endif
